// ==== sources.f ====
verilog/hello_pkg.sv
verilog/reg_bus_if.sv
verilog/axil_reg_slave.sv
verilog/hello_regs.sv
verilog/tick_counter.sv
verilog/vled_mask.sv
verilog/cl_hello_top.sv
verification/tb_hello_top.sv

// ==== Makefile ====
# Verilator build and run for the hello-world block

SIM        := verilator
TOP        := tb_hello_top
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Result decided by the log contents, not the exit code
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/tb_hello_top.sv ====
// Testbench for the hello-world block
// AXI-Lite register accesses, LED masking and event counter checks
// Expected values come from a register model in this file
`timescale 1ns/1ps

module tb_hello_top
  import hello_pkg::*;
;

  localparam int TIMEOUT_CYCLES = 100;
  localparam int CH_AW = 0;
  localparam int CH_W  = 1;
  localparam int CH_B  = 2;
  localparam int CH_AR = 3;
  localparam int CH_R  = 4;

  logic       clk_main_a0;
  logic       rst_main_n_sync;
  logic       ocl_awvalid;
  axil_addr_t ocl_awaddr;
  logic       ocl_awready;
  logic       ocl_wvalid;
  axil_data_t ocl_wdata;
  logic       ocl_wready;
  logic       ocl_bvalid;
  logic [1:0] ocl_bresp;
  logic       ocl_bready;
  logic       ocl_arvalid;
  axil_addr_t ocl_araddr;
  logic       ocl_arready;
  logic       ocl_rvalid;
  axil_data_t ocl_rdata;
  logic [1:0] ocl_rresp;
  logic       ocl_rready;
  vled_t      status_vdip;
  vled_t      status_vled;

  // Register model
  axil_data_t model_hello;
  logic       model_enable;
  logic       model_oneshot;
  cnt_t       model_count;
  cnt_t       model_wmark;

  logic [31:0] lfsr_state;
  int          data_errors;
  int          resp_errors;
  int          flag_errors;
  int          vled_errors;
  int          hang_errors;

  cl_hello_top dut (.*);

  // 40 ns clock
  initial begin
    clk_main_a0 = 1'b0;
    forever #20 clk_main_a0 = ~clk_main_a0;
  end

  // --------------------
  // Random source, Galois LFSR, one step per bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic axil_data_t random_bits(input int nbits);
    axil_data_t w = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
    return w;
  endfunction

  // --------------------
  // Expected read data from the register model
  function automatic axil_data_t ref_read(input axil_addr_t addr);
    axil_data_t v;
    v = UNIMPLEMENTED_VALUE;
    case (addr)
      HELLO_WORLD_ADDR: begin
        // Byte i comes from byte 3-i
        for (int i = 0; i < 4; i++) begin
          v[8*i +: 8] = model_hello[8*(3-i) +: 8];
        end
      end
      VLED_ADDR:       v = {16'h0, model_hello[15:0]};
      CNT_CTRL_ADDR:   v = {30'h0, model_oneshot, model_enable};
      CNT_STATUS_ADDR: v = {15'h0, (model_count >= model_wmark), model_count};
      default:         v = UNIMPLEMENTED_VALUE;
    endcase
    return v;
  endfunction

  // --------------------
  // Compare tasks
  task automatic check_data(input axil_data_t got, input axil_data_t exp, input string what);
    if (got !== exp) begin
      data_errors++;
      $display("FAILED at %0t: %s got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
    if (got !== exp) begin
      resp_errors++;
      $display("FAILED at %0t: %s got %0b expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flag_errors++;
      $display("FAILED at %0t: %s got %0b expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic check_vled(input vled_t got, input vled_t exp, input string what);
    if (got !== exp) begin
      vled_errors++;
      $display("FAILED at %0t: %s got %04h expected %04h", $time, what, got, exp);
    end
  endtask

  task automatic print_counts();
    $display("Errors: data %0d, resp %0d, flag %0d, led %0d, timeout %0d",
             data_errors, resp_errors, flag_errors, vled_errors, hang_errors);
  endtask

  // Hung channel ends the run
  task automatic abort_on_hang(input string what);
    hang_errors++;
    $display("Timeout: %s gave no response within %0d cycles", what, TIMEOUT_CYCLES);
    print_counts();
    $display("sim failed");
    $finish;
  endtask

  // Ready or valid sampled mid-cycle, transfer happens at the next rising edge
  task automatic wait_for(input int ch, input string what);
    int   n;
    logic hit;
    n   = 0;
    hit = 1'b0;
    while (!hit && n < TIMEOUT_CYCLES) begin
      @(negedge clk_main_a0);
      case (ch)
        CH_AW:   hit = ocl_awready;
        CH_W:    hit = ocl_wready;
        CH_B:    hit = ocl_bvalid;
        CH_AR:   hit = ocl_arready;
        default: hit = ocl_rvalid;
      endcase
      n++;
    end
    if (!hit) begin
      abort_on_hang(what);
    end
  endtask

  // --------------------
  // AXI-Lite bus tasks
  task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
    @(posedge clk_main_a0);
    #2;
    ocl_awvalid = 1'b1;
    ocl_awaddr  = addr;
    wait_for(CH_AW, "write address channel");
    @(posedge clk_main_a0);
    #2;
    ocl_awvalid = 1'b0;
    ocl_wvalid  = 1'b1;
    ocl_wdata   = data;
    wait_for(CH_W, "write data channel");
    @(posedge clk_main_a0);
    #2;
    ocl_wvalid = 1'b0;
    ocl_bready = 1'b1;
    wait_for(CH_B, "write response channel");
    check_resp(ocl_bresp, AXI_RESP_OKAY, "bresp");
    @(posedge clk_main_a0);
    #2;
    ocl_bready = 1'b0;
  endtask

  // hold is the number of cycles rready stays low once rvalid is up
  task automatic axil_read(input axil_addr_t addr, input int hold, output axil_data_t data);
    axil_data_t first;
    @(posedge clk_main_a0);
    #2;
    ocl_arvalid = 1'b1;
    ocl_araddr  = addr;
    wait_for(CH_AR, "read address channel");
    @(posedge clk_main_a0);
    #2;
    ocl_arvalid = 1'b0;
    wait_for(CH_R, "read data channel");
    first = ocl_rdata;
    check_resp(ocl_rresp, AXI_RESP_OKAY, "rresp");
    for (int i = 0; i < hold; i++) begin
      @(negedge clk_main_a0);
      check_flag(ocl_rvalid, 1'b1, "rvalid under back-pressure");
      check_flag(ocl_arready, 1'b0, "arready under back-pressure");
      check_data(ocl_rdata, first, "rdata under back-pressure");
    end
    @(posedge clk_main_a0);
    #2;
    ocl_rready = 1'b1;
    @(posedge clk_main_a0);
    #2;
    ocl_rready = 1'b0;
    data = first;
  endtask

  // --------------------
  // Stimulus and checks
  initial begin
    axil_data_t got;
    axil_data_t word;
    vled_t      dip;
    vled_t      exp_vled;
    int         polls;
    axil_addr_t holes [5];
    cnt_t       loads [3];
    rst_main_n_sync = 1'b0;
    ocl_awvalid     = 1'b0;
    ocl_awaddr      = '0;
    ocl_wvalid      = 1'b0;
    ocl_wdata       = '0;
    ocl_bready      = 1'b0;
    ocl_arvalid     = 1'b0;
    ocl_araddr      = '0;
    ocl_rready      = 1'b0;
    status_vdip     = '0;
    lfsr_state      = 32'h5cce2d47;
    model_hello     = '0;
    model_enable    = 1'b0;
    model_oneshot   = 1'b0;
    model_count     = '0;
    model_wmark     = '0;
    data_errors     = 0;
    resp_errors     = 0;
    flag_errors     = 0;
    vled_errors     = 0;
    hang_errors     = 0;
    repeat (16) @(posedge clk_main_a0);
    #2;
    rst_main_n_sync = 1'b1;

    // Reset values
    @(negedge clk_main_a0);
    check_flag(ocl_awready, 1'b1, "awready after reset");
    check_flag(ocl_arready, 1'b1, "arready after reset");
    check_flag(ocl_wready, 1'b0, "wready after reset");
    check_flag(ocl_bvalid, 1'b0, "bvalid after reset");
    check_flag(ocl_rvalid, 1'b0, "rvalid after reset");
    check_vled(status_vled, '0, "LED after reset");

    // Hello-world byte swap
    for (int i = 0; i < 6; i++) begin
      word = random_bits(32);
      axil_write(HELLO_WORLD_ADDR, word);
      model_hello = word;
      axil_read(HELLO_WORLD_ADDR, 0, got);
      check_data(got, ref_read(HELLO_WORLD_ADDR), "hello-world readback");
    end

    // Holes in the map, tick register is write-only
    holes = '{32'h0000_0000, CNT_TICK_ADDR, 32'h0000_051C, 32'h0000_04FC, 32'hFFFF_FFFC};
    foreach (holes[i]) begin
      axil_read(holes[i], 0, got);
      check_data(got, ref_read(holes[i]), "unmapped read");
    end
    axil_read(VLED_ADDR, 0, got);
    check_data(got, ref_read(VLED_ADDR), "LED shadow read");

    // LED masked by synchronized DIP
    for (int i = 0; i < 4; i++) begin
      word = random_bits(32);
      axil_write(HELLO_WORLD_ADDR, word);
      model_hello = word;
      dip = vled_t'(random_bits(16));
      exp_vled = model_hello[15:0] & dip;
      @(posedge clk_main_a0);
      #2;
      status_vdip = dip;
      polls = 0;
      while (polls < 3 || (status_vled !== exp_vled && polls < TIMEOUT_CYCLES)) begin
        @(negedge clk_main_a0);
        polls++;
      end
      check_vled(status_vled, exp_vled, "masked LED");
    end

    // --------------------
    // Counter disabled, load, watermark and clear
    model_wmark = vled_t'(random_bits(16)) | 16'h0001;
    axil_write(CNT_WMARK_ADDR, {16'h0, model_wmark});
    axil_write(CNT_CTRL_ADDR, 32'h0);
    loads = '{cnt_t'(random_bits(16)), model_wmark, model_wmark - 16'h1};
    foreach (loads[i]) begin
      axil_write(CNT_LOAD_ADDR, {16'h0, loads[i]});
      model_count = loads[i];
      axil_read(CNT_STATUS_ADDR, 0, got);
      check_data(got, ref_read(CNT_STATUS_ADDR), "loaded count");
    end
    axil_write(CNT_CTRL_ADDR, 32'h4);
    model_count = '0;
    axil_read(CNT_STATUS_ADDR, 0, got);
    check_data(got, ref_read(CNT_STATUS_ADDR), "count after clear");
    axil_read(CNT_CTRL_ADDR, 0, got);
    check_data(got, ref_read(CNT_CTRL_ADDR), "control readback");

    // One-shot run from 0xFFF0, one step per cycle
    axil_write(CNT_TICK_ADDR, 32'h0);
    axil_write(CNT_LOAD_ADDR, 32'h0000_FFF0);
    model_count = 16'hFFF0;
    axil_write(CNT_CTRL_ADDR, 32'h3);
    model_enable  = 1'b1;
    model_oneshot = 1'b1;
    polls = 0;
    got   = '0;
    while (got[15:0] != 16'hFFFF && polls < TIMEOUT_CYCLES) begin
      axil_read(CNT_STATUS_ADDR, 0, got);
      polls++;
    end
    if (got[15:0] != 16'hFFFF) begin
      abort_on_hang("one-shot counter saturation");
    end
    model_count = 16'hFFFF;
    repeat (3) begin
      axil_read(CNT_STATUS_ADDR, 0, got);
      check_data(got, ref_read(CNT_STATUS_ADDR), "saturated count");
    end
    axil_read(CNT_CTRL_ADDR, 0, got);
    check_data(got, ref_read(CNT_CTRL_ADDR), "control readback");

    // --------------------
    // Read back-pressure
    word = random_bits(32);
    axil_write(HELLO_WORLD_ADDR, word);
    model_hello = word;
    axil_read(HELLO_WORLD_ADDR, 6, got);
    check_data(got, ref_read(HELLO_WORLD_ADDR), "read under back-pressure");
    @(negedge clk_main_a0);
    check_flag(ocl_arready, 1'b1, "arready after read handshake");

    print_counts();
    if (data_errors + resp_errors + flag_errors + vled_errors + hang_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== verilog/cl_hello_top.sv ====
// Hello-world block top level
// AXI-Lite slave, register file, event counter and virtual LED output
`timescale 1ns/1ps

module cl_hello_top
  import hello_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  input  logic       ocl_awvalid,
  input  axil_addr_t ocl_awaddr,
  output logic       ocl_awready,
  input  logic       ocl_wvalid,
  input  axil_data_t ocl_wdata,
  output logic       ocl_wready,
  output logic       ocl_bvalid,
  output logic [1:0] ocl_bresp,
  input  logic       ocl_bready,
  input  logic       ocl_arvalid,
  input  axil_addr_t ocl_araddr,
  output logic       ocl_arready,
  output logic       ocl_rvalid,
  output axil_data_t ocl_rdata,
  output logic [1:0] ocl_rresp,
  input  logic       ocl_rready,
  input  vled_t      status_vdip,
  output vled_t      status_vled
);

  cnt_ctrl_t   cnt_ctrl;
  cnt_status_t cnt_status;
  vled_t       hello_low;
  vled_t       vled_shadow;

  // Register access bus
  reg_bus_if bus ();

  // --------------------
  // Bus front end
  axil_reg_slave u_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (ocl_awvalid),
    .awaddr          (ocl_awaddr),
    .awready         (ocl_awready),
    .wvalid          (ocl_wvalid),
    .wdata           (ocl_wdata),
    .wready          (ocl_wready),
    .bvalid          (ocl_bvalid),
    .bresp           (ocl_bresp),
    .bready          (ocl_bready),
    .arvalid         (ocl_arvalid),
    .araddr          (ocl_araddr),
    .arready         (ocl_arready),
    .rvalid          (ocl_rvalid),
    .rdata           (ocl_rdata),
    .rresp           (ocl_rresp),
    .rready          (ocl_rready),
    .bus             (bus.host)
  );

  hello_regs u_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .bus             (bus.target),
    .cnt_ctrl        (cnt_ctrl),
    .cnt_status      (cnt_status),
    .vled_shadow     (vled_shadow),
    .hello_low       (hello_low)
  );

  // --------------------
  // Function blocks
  tick_counter u_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .ctrl            (cnt_ctrl),
    .status          (cnt_status)
  );

  vled_mask u_vled (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .hello_low       (hello_low),
    .vdip            (status_vdip),
    .vled_shadow     (vled_shadow),
    .vled            (status_vled)
  );

endmodule

// ==== verilog/vled_mask.sv ====
// Virtual LED output
// Shadows the low hello-world half, masked by the synchronized DIP switches
`timescale 1ns/1ps

module vled_mask
  import hello_pkg::*;
(
  input  logic  clk_main_a0,
  input  logic  rst_main_n_sync,
  input  vled_t hello_low,
  input  vled_t vdip,
  output vled_t vled_shadow,
  output vled_t vled
);

  vled_t dip_q1;
  vled_t dip_q2;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_shadow <= '0;
      dip_q1      <= '0;
      dip_q2      <= '0;
      vled        <= '0;
    end else begin
      // Shadow copy of the register
      vled_shadow <= hello_low;
      // DIP inputs are asynchronous, two-flop sync
      dip_q1      <= vdip;
      dip_q2      <= dip_q1;
      // Output flop after the mask
      vled        <= vled_shadow & dip_q2;
    end
  end

  // A lit LED needs its switch closed at the pin three cycles earlier
  a_vled_masked : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (vled & ~$past(vdip, 3)) == '0)
    else $error("LED set with its DIP switch open");

endmodule

// ==== verilog/tick_counter.sv ====
// Prescaled event counter
// Prescaler wraps at the tick value, each wrap advances the count
// Clear, load, one-shot saturation and a watermark compare
`timescale 1ns/1ps

module tick_counter
  import hello_pkg::*;
(
  input  logic        clk_main_a0,
  input  logic        rst_main_n_sync,
  input  cnt_ctrl_t   ctrl,
  output cnt_status_t status
);

  cnt_ctrl_t ctrl_q;
  tick_t     tick_cnt;
  cnt_t      count;
  logic      wrap;

  // --------------------
  // Control re-registered at the counter
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= ctrl;
    end
  end

  // Prescaler end of period
  assign wrap = ctrl_q.enable && (tick_cnt >= ctrl_q.tick_value);

  // --------------------
  // Prescaler, frozen while disabled
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      tick_cnt <= '0;
    end else if (ctrl_q.clear) begin
      tick_cnt <= '0;
    end else if (wrap) begin
      tick_cnt <= '0;
    end else if (ctrl_q.enable) begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // --------------------
  // Main count
  // Clear wins over load, load over counting
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      count <= '0;
    end else if (ctrl_q.clear) begin
      count <= '0;
    end else if (ctrl_q.load) begin
      count <= ctrl_q.load_value;
    end else if (wrap) begin
      // Saturate in one-shot, roll over otherwise
      if (!(ctrl_q.oneshot && (count == CNT_MAX))) begin
        count <= count + 1'b1;
      end
    end
  end

  assign status.count        = count;
  assign status.ge_watermark = (count >= ctrl_q.watermark);
  assign status.tick         = wrap;

  // --------------------
  // One-shot count sticks at the top unless cleared or reloaded
  a_oneshot_sat : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    ctrl_q.oneshot && !ctrl_q.clear && !ctrl_q.load && (count == CNT_MAX)
      |=> (count != '0))
    else $error("one-shot counter rolled over");

endmodule

// ==== verilog/hello_regs.sv ====
// Register file of the hello-world block
// Hello-world word, counter control registers and the read decode
// Hello-world reads back byte-reversed
`timescale 1ns/1ps

module hello_regs
  import hello_pkg::*;
(
  input  logic        clk_main_a0,
  input  logic        rst_main_n_sync,
  reg_bus_if.target   bus,
  output cnt_ctrl_t   cnt_ctrl,
  input  cnt_status_t cnt_status,
  input  vled_t       vled_shadow,
  output vled_t       hello_low
);

  axil_data_t hello_q;
  axil_data_t hello_swapped;
  logic       enable_q;
  logic       oneshot_q;
  logic       clear_pulse;
  logic       load_pulse;
  tick_t      tick_value_q;
  cnt_t       load_value_q;
  cnt_t       watermark_q;
  logic       wr_hello;
  logic       wr_ctrl;
  logic       wr_tick;
  logic       wr_load;
  logic       wr_wmark;

  // --------------------
  // Write decode
  assign wr_hello = bus.wr_en && (bus.wr_addr == HELLO_WORLD_ADDR);
  assign wr_ctrl  = bus.wr_en && (bus.wr_addr == CNT_CTRL_ADDR);
  assign wr_tick  = bus.wr_en && (bus.wr_addr == CNT_TICK_ADDR);
  assign wr_load  = bus.wr_en && (bus.wr_addr == CNT_LOAD_ADDR);
  assign wr_wmark = bus.wr_en && (bus.wr_addr == CNT_WMARK_ADDR);

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q      <= '0;
      enable_q     <= 1'b0;
      oneshot_q    <= 1'b0;
      clear_pulse  <= 1'b0;
      load_pulse   <= 1'b0;
      tick_value_q <= '0;
      load_value_q <= '0;
      watermark_q  <= '0;
    end else begin
      if (wr_hello) begin
        hello_q <= bus.wr_data;
      end
      if (wr_ctrl) begin
        enable_q  <= bus.wr_data[CTRL_ENABLE_BIT];
        oneshot_q <= bus.wr_data[CTRL_ONESHOT_BIT];
      end
      if (wr_tick) begin
        tick_value_q <= bus.wr_data[TICK_W-1:0];
      end
      // Load value and its pulse arrive together at the counter
      if (wr_load) begin
        load_value_q <= bus.wr_data[CNT_W-1:0];
      end
      if (wr_wmark) begin
        watermark_q <= bus.wr_data[CNT_W-1:0];
      end
      // Self-clearing strobes
      clear_pulse <= wr_ctrl && bus.wr_data[CTRL_CLEAR_BIT];
      load_pulse  <= wr_load;
    end
  end

  // Byte order reversed on read
  assign hello_swapped = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};

  // LED shadow source
  assign hello_low = hello_q[VLED_W-1:0];

  assign cnt_ctrl = '{
    enable:     enable_q,
    oneshot:    oneshot_q,
    clear:      clear_pulse,
    load:       load_pulse,
    tick_value: tick_value_q,
    load_value: load_value_q,
    watermark:  watermark_q
  };

  // --------------------
  // Read decode
  // Tick, load and watermark are write-only
  always_comb begin
    case (bus.rd_addr)
      HELLO_WORLD_ADDR: bus.rd_data = hello_swapped;
      VLED_ADDR:        bus.rd_data = {{(AXIL_DATA_W-VLED_W){1'b0}}, vled_shadow};
      CNT_CTRL_ADDR:    bus.rd_data = {{(AXIL_DATA_W-2){1'b0}}, oneshot_q, enable_q};
      CNT_STATUS_ADDR:  bus.rd_data = {{(AXIL_DATA_W-CNT_W-1){1'b0}},
                                       cnt_status.ge_watermark, cnt_status.count};
      default:          bus.rd_data = UNIMPLEMENTED_VALUE;
    endcase
  end

endmodule

// ==== verilog/axil_reg_slave.sv ====
// AXI-Lite slave, single-beat accesses only
// Converts AW/W/B and AR/R transactions into register bus strobes
// Full-word writes, OKAY response on every access
`timescale 1ns/1ps

module axil_reg_slave
  import hello_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  input  logic       awvalid,
  input  axil_addr_t awaddr,
  output logic       awready,
  input  logic       wvalid,
  input  axil_data_t wdata,
  output logic       wready,
  output logic       bvalid,
  output logic [1:0] bresp,
  input  logic       bready,
  input  logic       arvalid,
  input  axil_addr_t araddr,
  output logic       arready,
  output logic       rvalid,
  output axil_data_t rdata,
  output logic [1:0] rresp,
  input  logic       rready,
  reg_bus_if.host    bus
);

  logic       wr_active;
  axil_addr_t wr_addr_q;
  logic       rd_pending;
  axil_addr_t rd_addr_q;
  logic       aw_hs;
  logic       w_hs;
  logic       ar_hs;

  // --------------------
  // Write path
  // One write in flight, AW closed until B completes
  assign awready = !wr_active;
  // No second W beat once the response is pending
  assign wready  = wr_active && wvalid && !bvalid;
  assign aw_hs   = awvalid && awready;
  assign w_hs    = wvalid && wready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
    end else if (bvalid && bready) begin
      wr_active <= 1'b0;
    end else if (aw_hs) begin
      wr_active <= 1'b1;
    end
  end

  // Address held for the W beat
  always_ff @(posedge clk_main_a0) begin
    if (aw_hs) begin
      wr_addr_q <= awaddr;
    end
  end

  // Response one cycle after W, held until bready
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      bvalid <= 1'b0;
    end else if (bvalid && bready) begin
      bvalid <= 1'b0;
    end else if (w_hs) begin
      bvalid <= 1'b1;
    end
  end

  assign bresp = AXI_RESP_OKAY;

  // Register write strobe in the W handshake cycle
  assign bus.wr_en   = w_hs;
  assign bus.wr_addr = wr_addr_q;
  assign bus.wr_data = wdata;

  // --------------------
  // Read path
  // Closed while an address is captured or data is waiting
  assign arready = !rd_pending && !rvalid;
  assign ar_hs   = arvalid && arready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= ar_hs;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (ar_hs) begin
      rd_addr_q <= araddr;
    end
  end

  assign bus.rd_en   = rd_pending;
  assign bus.rd_addr = rd_addr_q;

  // Data sampled from the register file in the rd_en cycle
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rvalid <= 1'b0;
    end else if (bus.rd_en) begin
      rvalid <= 1'b1;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
    end
  end

  // Held stable under back-pressure
  always_ff @(posedge clk_main_a0) begin
    if (bus.rd_en) begin
      rdata <= bus.rd_data;
    end
  end

  assign rresp = AXI_RESP_OKAY;

  // --------------------
  // Checks
  // Response must not be withdrawn by the slave
  a_bvalid_hold : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  // Read data stays put while the master stalls
  a_r_hold : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("read data changed before rready");

endmodule

// ==== verilog/reg_bus_if.sv ====
// Register access bus between the AXI-Lite slave and the register file
// Write and read strobes with address, data and combinational read return
`timescale 1ns/1ps

interface reg_bus_if
  import hello_pkg::*;
;

  // Write side, one-cycle strobe at the W handshake
  logic       wr_en;
  axil_addr_t wr_addr;
  axil_data_t wr_data;

  // Read side
  // rd_en marks the cycle in which the slave samples rd_data
  logic       rd_en;
  axil_addr_t rd_addr;
  axil_data_t rd_data;

  // Bus slave side
  modport host (
    output wr_en,
    output wr_addr,
    output wr_data,
    output rd_en,
    output rd_addr,
    input  rd_data
  );

  // Register file side, decodes rd_addr without a clock
  modport target (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_addr,
    output rd_data
  );

endinterface

// ==== verilog/hello_pkg.sv ====
// Hello-world block shared definitions
// Bus and LED widths, register map and the counter control/status types
package hello_pkg;

  // --------------------
  // Widths
  localparam int AXIL_ADDR_W = 32;
  localparam int AXIL_DATA_W = 32;
  localparam int VLED_W      = 16;
  localparam int CNT_W       = 16;
  localparam int TICK_W      = 8;

  typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [VLED_W-1:0]      vled_t;
  typedef logic [CNT_W-1:0]       cnt_t;
  typedef logic [TICK_W-1:0]      tick_t;

  // --------------------
  // Register map
  localparam axil_addr_t HELLO_WORLD_ADDR = 32'h0000_0500;
  localparam axil_addr_t VLED_ADDR        = 32'h0000_0504;
  localparam axil_addr_t CNT_CTRL_ADDR    = 32'h0000_0508;
  localparam axil_addr_t CNT_TICK_ADDR    = 32'h0000_050C;
  localparam axil_addr_t CNT_LOAD_ADDR    = 32'h0000_0510;
  localparam axil_addr_t CNT_WMARK_ADDR   = 32'h0000_0514;
  localparam axil_addr_t CNT_STATUS_ADDR  = 32'h0000_0518;

  // Bit positions in the counter control word
  localparam int CTRL_ENABLE_BIT  = 0;
  localparam int CTRL_ONESHOT_BIT = 1;
  localparam int CTRL_CLEAR_BIT   = 2;

  // Read value for holes in the map
  localparam axil_data_t UNIMPLEMENTED_VALUE = 32'hDEAD_DEAD;
  localparam logic [1:0] AXI_RESP_OKAY       = 2'b00;

  // Saturation point of the one-shot counter
  localparam cnt_t CNT_MAX = 16'hFFFF;

  // --------------------
  // Counter control, clear and load are single-cycle pulses
  typedef struct packed {
    logic  enable;
    logic  oneshot;
    logic  clear;
    logic  load;
    tick_t tick_value;
    cnt_t  load_value;
    cnt_t  watermark;
  } cnt_ctrl_t;

  // Counter status back to the register file
  typedef struct packed {
    cnt_t count;
    logic ge_watermark;
    logic tick;
  } cnt_status_t;

endpackage
